// ==== hdl/dispatch_unit.sv ====
`timescale 1ns/10ps

module dispatch_unit
    import isa_pkg::*;
    import sched_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  opcode_t    opcode,
    input  reg_index_t dest,
    input  reg_index_t src1,
    input  reg_index_t src2,
    input  reg_index_t reg_read_index,
    input  logic       alu_entry_free,
    input  logic       mult_entry_free,
    input  logic       cdb_valid,
    input  tag_t       cdb_tag,
    input  reg_index_t cdb_dest,
    input  data_t      cdb_value,
    output logic       dispatch_stall,
    output data_t      reg_read_value,
    output logic       alloc_valid,
    output fu_class_t  alloc_class,
    output opcode_t    alloc_opcode,
    output reg_index_t alloc_dest,
    output tag_t       alloc_tag,
    output tag_t       src1_tag,
    output data_t      src1_value,
    output tag_t       src2_tag,
    output data_t      src2_value
);

    data_t     regs      [NUM_REGS];    // Register file
    tag_t      map_table [NUM_REGS];    // Pending producer per register
    tag_t      next_tag;                // Tag counter that skips TAG_READY
    fu_class_t dec_class;
    logic      accept;

    // Tag and value of one source with CDB bypass
    function automatic logic [TAG_W+DATA_W-1:0] read_source(reg_index_t idx);
        tag_t t;
        t = map_table[idx];
        if (t == TAG_READY)
            return {TAG_READY, regs[idx]};
        if (cdb_valid && cdb_tag == t)
            return {TAG_READY, cdb_value};  // Producer broadcasting right now
        return {t, regs[idx]};
    endfunction

    assign dec_class = op_class(opcode);

    // Stall from registered free levels only
    assign dispatch_stall = (dec_class == FU_MULT) ? !mult_entry_free : !alu_entry_free;
    assign accept         = dispatch_valid && !dispatch_stall;

    assign alloc_valid  = accept;
    assign alloc_class  = dec_class;
    assign alloc_opcode = opcode;
    assign alloc_dest   = dest;
    assign alloc_tag    = next_tag;

    always_comb begin
        {src1_tag, src1_value} = read_source(src1);
        {src2_tag, src2_value} = read_source(src2);
    end

    assign reg_read_value = regs[reg_read_index];  // Debug read

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            next_tag <= tag_t'(1);
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i]      <= data_t'(i);  // Register i starts at i
                map_table[i] <= TAG_READY;
            end
        end else begin
            // Writeback only if no younger rename of this register
            if (cdb_valid && map_table[cdb_dest] == cdb_tag) begin
                regs[cdb_dest]      <= cdb_value;
                map_table[cdb_dest] <= TAG_READY;
            end
            // Rename wins over a same-cycle clear
            if (accept) begin
                map_table[dest] <= next_tag;
                next_tag        <= (next_tag == '1) ? tag_t'(1) : next_tag + tag_t'(1);
            end
        end
    end

    // A strobe held through a stall renames nothing
    a_no_accept_stalled: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid && dispatch_stall |=> $stable(next_tag));

endmodule

// ==== hdl/exec_cluster.sv ====
`timescale 1ns/10ps

module exec_cluster
    import isa_pkg::*;
    import sched_pkg::*;
#(
    parameter  int NUM_ALU_RS  = 4,
    parameter  int NUM_MULT_RS = 2,
    parameter  int MULT_STAGES = 3,
    localparam int NUM_RS      = NUM_ALU_RS + NUM_MULT_RS
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [NUM_RS-1:0]        ready_vec,
    input  logic [NUM_RS*OP_W-1:0]   entry_opcode,
    input  logic [NUM_RS*DATA_W-1:0] entry_op_a,
    input  logic [NUM_RS*DATA_W-1:0] entry_op_b,
    input  logic [NUM_RS*TAG_W-1:0]  entry_tag,
    input  logic [NUM_RS*REG_W-1:0]  entry_dest,
    output logic [NUM_RS-1:0]        issue_alu_vec,
    output logic [NUM_RS-1:0]        issue_mult_vec,
    output logic                     cdb_valid,
    output tag_t                     cdb_tag,
    output reg_index_t               cdb_dest,
    output data_t                    cdb_value
);

    localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;

    logic [IDX_W-1:0]       alu_idx, mult_idx;
    logic                   alu_found, mult_found;
    logic                   alu_go, mult_go, alu_block;
    opcode_t                alu_op;
    data_t                  alu_a, alu_b, alu_result, mult_product;
    logic                   alu_valid;                // ALU output register
    tag_t                   alu_tag;
    reg_index_t             alu_dest;
    data_t                  alu_value;
    logic [MULT_STAGES-1:0] mult_valid;               // Multiplier pipe, stage 0 first
    tag_t                   mult_tag   [MULT_STAGES];
    reg_index_t             mult_dest  [MULT_STAGES];
    data_t                  mult_value [MULT_STAGES];

    // Lowest ready entry per class
    always_comb begin
        alu_found  = 1'b0;
        alu_idx    = '0;
        mult_found = 1'b0;
        mult_idx   = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (ready_vec[i] && i < NUM_ALU_RS) begin
                alu_found = 1'b1;
                alu_idx   = IDX_W'(i);
            end else if (ready_vec[i]) begin
                mult_found = 1'b1;
                mult_idx   = IDX_W'(i);
            end
        end
    end

    // Hold ALU back when a multiply lands on the CDB next cycle
    generate
        if (MULT_STAGES > 1) begin : g_hazard_pipe
            assign alu_block = mult_valid[MULT_STAGES-2];
        end else begin : g_hazard_single
            assign alu_block = mult_go;
        end
    endgenerate

    assign mult_go = mult_found;
    assign alu_go  = alu_found && !alu_block;

    always_comb begin
        issue_alu_vec  = '0;
        issue_mult_vec = '0;
        if (alu_go)
            issue_alu_vec[alu_idx] = 1'b1;
        if (mult_go)
            issue_mult_vec[mult_idx] = 1'b1;
    end

    assign alu_op       = opcode_t'(entry_opcode[alu_idx*OP_W +: OP_W]);
    assign alu_a        = entry_op_a[alu_idx*DATA_W +: DATA_W];
    assign alu_b        = entry_op_b[alu_idx*DATA_W +: DATA_W];
    assign mult_product = entry_op_a[mult_idx*DATA_W +: DATA_W] *
                          entry_op_b[mult_idx*DATA_W +: DATA_W];  // Low half kept

    always_comb begin
        case (alu_op)
            OP_SUB:  alu_result = alu_a - alu_b;
            OP_AND:  alu_result = alu_a & alu_b;
            OP_OR:   alu_result = alu_a | alu_b;
            OP_XOR:  alu_result = alu_a ^ alu_b;
            default: alu_result = alu_a + alu_b;  // OP_ADD
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid  <= 1'b0;
            mult_valid <= '0;
        end else begin
            alu_valid  <= alu_go;
            mult_valid <= (mult_valid << 1) | MULT_STAGES'(mult_go);
        end
    end

    // Tag and dest ride along with each result
    always_ff @(posedge clock) begin
        if (alu_go) begin
            alu_tag   <= entry_tag[alu_idx*TAG_W +: TAG_W];
            alu_dest  <= entry_dest[alu_idx*REG_W +: REG_W];
            alu_value <= alu_result;
        end
        mult_tag[0]   <= entry_tag[mult_idx*TAG_W +: TAG_W];
        mult_dest[0]  <= entry_dest[mult_idx*REG_W +: REG_W];
        mult_value[0] <= mult_product;
        for (int s = 1; s < MULT_STAGES; s++) begin
            mult_tag[s]   <= mult_tag[s-1];
            mult_dest[s]  <= mult_dest[s-1];
            mult_value[s] <= mult_value[s-1];
        end
    end

    // Multiplier first on the CDB
    assign cdb_valid = alu_valid || mult_valid[MULT_STAGES-1];

    always_comb begin
        if (mult_valid[MULT_STAGES-1]) begin
            cdb_tag   = mult_tag[MULT_STAGES-1];
            cdb_dest  = mult_dest[MULT_STAGES-1];
            cdb_value = mult_value[MULT_STAGES-1];
        end else begin
            cdb_tag   = alu_tag;
            cdb_dest  = alu_dest;
            cdb_value = alu_value;
        end
    end

    // Issue-time hazard check keeps the two results apart
    a_one_result: assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mult_valid[MULT_STAGES-1]));

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    localparam int NUM_REGS = 8;                 // Architectural registers
    localparam int REG_W    = $clog2(NUM_REGS);
    localparam int DATA_W   = 16;                // Product keeps low 16 bits
    localparam int OP_W     = 3;

    // Integer opcodes, no memory or branch ops
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } opcode_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_class_t;

    typedef logic [REG_W-1:0]  reg_index_t;
    typedef logic [DATA_W-1:0] data_t;

    // Unit class of an opcode
    function automatic fu_class_t op_class(opcode_t op);
        return (op == OP_MUL) ? FU_MULT : FU_ALU;
    endfunction

endpackage

// ==== hdl/reservation_station.sv ====
`timescale 1ns/10ps

module reservation_station
    import isa_pkg::*;
    import sched_pkg::*;
#(
    parameter  int NUM_ALU_RS  = 4,
    parameter  int NUM_MULT_RS = 2,
    localparam int NUM_RS      = NUM_ALU_RS + NUM_MULT_RS
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     alloc_valid,
    input  fu_class_t                alloc_class,
    input  opcode_t                  alloc_opcode,
    input  reg_index_t               alloc_dest,
    input  tag_t                     alloc_tag,
    input  tag_t                     src1_tag,
    input  data_t                    src1_value,
    input  tag_t                     src2_tag,
    input  data_t                    src2_value,
    input  logic                     cdb_valid,
    input  tag_t                     cdb_tag,
    input  reg_index_t               cdb_dest,
    input  data_t                    cdb_value,
    input  logic [NUM_RS-1:0]        issue_alu_vec,
    input  logic [NUM_RS-1:0]        issue_mult_vec,
    output logic                     alu_entry_free,
    output logic                     mult_entry_free,
    output logic [NUM_RS-1:0]        ready_vec,
    output logic [NUM_RS*OP_W-1:0]   entry_opcode,
    output logic [NUM_RS*DATA_W-1:0] entry_op_a,
    output logic [NUM_RS*DATA_W-1:0] entry_op_b,
    output logic [NUM_RS*TAG_W-1:0]  entry_tag,
    output logic [NUM_RS*REG_W-1:0]  entry_dest
);

    localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;
    // Low entries are ALU, upper ones multiply
    localparam logic [NUM_RS-1:0] ALU_MASK = {NUM_RS{1'b1}} >> NUM_MULT_RS;

    rs_entry_t         entry [NUM_RS];
    logic [NUM_RS-1:0] free_vec;
    logic [IDX_W-1:0]  alloc_idx;
    logic              alloc_hit;
    logic              tag_dup;        // Two live entries share a tag
    logic              cdb_owner_ok;   // Broadcast matches a live entry and its dest

    always_comb begin
        for (int i = 0; i < NUM_RS; i++)
            free_vec[i] = !entry[i].busy;
    end

    assign alu_entry_free  = |(free_vec & ALU_MASK);
    assign mult_entry_free = |(free_vec & ~ALU_MASK);

    // Lowest free entry of the requested class
    always_comb begin
        alloc_hit = 1'b0;
        alloc_idx = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (free_vec[i] && (ALU_MASK[i] == (alloc_class == FU_ALU))) begin
                alloc_hit = 1'b1;
                alloc_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_RS; i++)
                entry[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_RS; i++) begin
                if (entry[i].busy && cdb_valid && cdb_tag == entry[i].own_tag) begin
                    entry[i].busy   <= 1'b0;  // Own result broadcast
                    entry[i].issued <= 1'b0;
                end else if (entry[i].busy) begin
                    // Snoop, cdb_tag is never TAG_READY
                    if (cdb_valid && cdb_tag == entry[i].tag1) begin
                        entry[i].tag1 <= TAG_READY;
                        entry[i].val1 <= cdb_value;
                    end
                    if (cdb_valid && cdb_tag == entry[i].tag2) begin
                        entry[i].tag2 <= TAG_READY;
                        entry[i].val2 <= cdb_value;
                    end
                    if (issue_alu_vec[i] || issue_mult_vec[i])
                        entry[i].issued <= 1'b1;
                end else if (alloc_valid && alloc_hit && alloc_idx == IDX_W'(i)) begin
                    entry[i] <= '{busy:    1'b1,
                                  issued:  1'b0,
                                  opcode:  alloc_opcode,
                                  tag1:    src1_tag,
                                  val1:    src1_value,
                                  tag2:    src2_tag,
                                  val2:    src2_value,
                                  dest:    alloc_dest,
                                  own_tag: alloc_tag};
                end
            end
        end
    end

    // Flattened views for the execution block
    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            ready_vec[i] = entry[i].busy && !entry[i].issued &&
                           entry[i].tag1 == TAG_READY && entry[i].tag2 == TAG_READY;
            entry_opcode[i*OP_W +: OP_W]     = entry[i].opcode;
            entry_op_a[i*DATA_W +: DATA_W]   = entry[i].val1;
            entry_op_b[i*DATA_W +: DATA_W]   = entry[i].val2;
            entry_tag[i*TAG_W +: TAG_W]      = entry[i].own_tag;
            entry_dest[i*REG_W +: REG_W]     = entry[i].dest;
        end
    end

    always_comb begin
        tag_dup      = 1'b0;
        cdb_owner_ok = 1'b0;
        for (int i = 0; i < NUM_RS; i++) begin
            for (int j = i + 1; j < NUM_RS; j++) begin
                if (entry[i].busy && entry[j].busy && entry[i].own_tag == entry[j].own_tag)
                    tag_dup = 1'b1;
            end
            if (entry[i].busy && entry[i].own_tag == cdb_tag && entry[i].dest == cdb_dest)
                cdb_owner_ok = 1'b1;
        end
    end

    // Issue select in the execution block picks only ready entries of its class
    a_issue_ready: assert property (@(posedge clock) disable iff (reset)
        ((issue_alu_vec & ~(ready_vec & ALU_MASK)) == '0) &&
        ((issue_mult_vec & ~(ready_vec & ~ALU_MASK)) == '0));

    // Tag counter wrap never reaches a live tag
    a_unique_tag: assert property (@(posedge clock) disable iff (reset) !tag_dup);

    a_cdb_owner: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_owner_ok);

endmodule

// ==== hdl/sched_core.sv ====
`timescale 1ns/10ps

module sched_core
    import isa_pkg::*;
    import sched_pkg::*;
#(
    parameter  int NUM_ALU_RS  = 4,
    parameter  int NUM_MULT_RS = 2,
    parameter  int MULT_STAGES = 3,
    localparam int NUM_RS      = NUM_ALU_RS + NUM_MULT_RS
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  opcode_t    opcode,
    input  reg_index_t dest,
    input  reg_index_t src1,
    input  reg_index_t src2,
    input  reg_index_t reg_read_index,
    output logic       dispatch_stall,
    output data_t      reg_read_value,
    output logic       cdb_valid,
    output tag_t       cdb_tag,
    output reg_index_t cdb_dest,
    output data_t      cdb_value
);

    // Dispatch to RS
    logic       alloc_valid;
    fu_class_t  alloc_class;
    opcode_t    alloc_opcode;
    reg_index_t alloc_dest;
    tag_t       alloc_tag;
    tag_t       src1_tag, src2_tag;
    data_t      src1_value, src2_value;
    logic       alu_entry_free, mult_entry_free;

    // RS to execution and back
    logic [NUM_RS-1:0]        ready_vec;
    logic [NUM_RS*OP_W-1:0]   entry_opcode;
    logic [NUM_RS*DATA_W-1:0] entry_op_a, entry_op_b;
    logic [NUM_RS*TAG_W-1:0]  entry_tag;
    logic [NUM_RS*REG_W-1:0]  entry_dest;
    logic [NUM_RS-1:0]        issue_alu_vec, issue_mult_vec;

    dispatch_unit u_dispatch (.*);

    reservation_station #(
        .NUM_ALU_RS  (NUM_ALU_RS),
        .NUM_MULT_RS (NUM_MULT_RS)
    ) u_rs (.*);

    exec_cluster #(
        .NUM_ALU_RS  (NUM_ALU_RS),
        .NUM_MULT_RS (NUM_MULT_RS),
        .MULT_STAGES (MULT_STAGES)
    ) u_exec (.*);

endmodule

// ==== hdl/sched_pkg.sv ====
package sched_pkg;

    import isa_pkg::*;

    localparam int TAG_W = 4;

    typedef logic [TAG_W-1:0] tag_t;

    // Tag zero marks a value as present, never handed out
    localparam tag_t TAG_READY = '0;

    // One reservation station slot
    typedef struct packed {
        logic       busy;
        logic       issued;     // Sent to a unit, waiting for own broadcast
        opcode_t    opcode;
        tag_t       tag1;       // Producer of operand 1, or TAG_READY
        data_t      val1;
        tag_t       tag2;
        data_t      val2;
        reg_index_t dest;
        tag_t       own_tag;    // Tag this entry broadcasts on
    } rs_entry_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sched_core.f \
    --top-module sched_core_tb -o sched_core_sim \
    && ./obj_dir/sched_core_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log && exit 0 || exit 1

// ==== sched_core.f ====
hdl/isa_pkg.sv
hdl/sched_pkg.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/exec_cluster.sv
hdl/sched_core.sv
testbench/sched_core_tb.sv

// ==== testbench/sched_core_tb.sv ====
`timescale 1ns/10ps

module sched_core_tb
    import isa_pkg::*;
    import sched_pkg::*;
();

    localparam int NUM_GROUPS  = 5;
    localparam int STALL_GROUP = 3;      // Multiply back-pressure group
    localparam int MULT_STAGES = 3;
    localparam int NUM_TAGS    = 2**TAG_W;

    typedef struct packed {
        opcode_t    op;
        reg_index_t dest;
        reg_index_t src1;
        reg_index_t src2;
        logic [3:0] group;
    } row_t;

    logic       clock, reset, dispatch_valid;
    opcode_t    opcode;
    reg_index_t dest, src1, src2, reg_read_index;
    logic       dispatch_stall, cdb_valid;
    data_t      reg_read_value, cdb_value;
    tag_t       cdb_tag;
    reg_index_t cdb_dest;

    row_t       prog [$];                 // Program table with all groups in order
    data_t      model [NUM_REGS];         // Reference registers in program order
    data_t      exp_value [NUM_TAGS];     // Expected result per tag in flight
    reg_index_t exp_dest [NUM_TAGS];
    logic       pending [NUM_TAGS];
    tag_t       next_exp_tag;
    int         outstanding, disp_count, cdb_count, stall_count;
    int         errors, checks, group_errors;
    integer     seed;
    string      test_name [NUM_GROUPS] = '{"independent ALU", "RAW chain", "WAW",
                                           "multiply back-pressure", "random CDB"};

    sched_core #(.NUM_ALU_RS(4), .NUM_MULT_RS(2), .MULT_STAGES(MULT_STAGES)) dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;       // 100 ns period
    end

    function automatic data_t model_result(opcode_t op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a * b;        // Low half of the product
        endcase
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_dest(input string name, input reg_index_t got, input reg_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic add_row(input opcode_t op, input int d, input int s1, input int s2,
                           input int g);
        prog.push_back(row_t'{op, reg_index_t'(d), reg_index_t'(s1), reg_index_t'(s2), 4'(g)});
    endtask

    task automatic build_table();
        add_row(OP_ADD, 1, 2, 3, 0);
        add_row(OP_SUB, 4, 5, 6, 0);
        add_row(OP_AND, 7, 3, 5, 0);
        add_row(OP_OR,  0, 6, 2, 0);
        add_row(OP_ADD, 1, 2, 3, 1);
        add_row(OP_XOR, 4, 5, 6, 1);
        add_row(OP_SUB, 7, 1, 4, 1);  // Producer of r1 on the CDB at dispatch
        add_row(OP_MUL, 2, 7, 1, 1);
        add_row(OP_ADD, 3, 2, 2, 1);
        add_row(OP_MUL, 6, 3, 2, 1);
        add_row(OP_OR,  0, 6, 3, 1);
        add_row(OP_MUL, 5, 5, 6, 2);
        add_row(OP_ADD, 5, 1, 2, 2);  // Younger finishes first
        add_row(OP_ADD, 6, 0, 1, 2);
        add_row(OP_MUL, 6, 6, 6, 2);  // Older finishes first
        add_row(OP_MUL, 1, 2, 3, 3);
        add_row(OP_MUL, 4, 5, 6, 3);
        add_row(OP_MUL, 7, 0, 3, 3);
        for (int i = 0; i < 24; i++)
            add_row(opcode_t'($unsigned($random(seed)) % 6), $unsigned($random(seed)) % 8,
                    $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8, 4);
    endtask

    // Model update and expected broadcast for one accepted row
    task automatic record_dispatch(input row_t r);
        data_t res;
        res                     = model_result(r.op, model[r.src1], model[r.src2]);
        model[r.dest]           = res;
        exp_value[next_exp_tag] = res;
        exp_dest[next_exp_tag]  = r.dest;
        pending[next_exp_tag]   = 1'b1;
        outstanding++;
        disp_count++;
        next_exp_tag = tag_t'(next_exp_tag % (NUM_TAGS - 1) + 1);  // Tags cycle 1 to 15
    endtask

    // Hold the strobe until a cycle without stall
    task automatic dispatch_row(input row_t r);
        logic done;
        done           = 1'b0;
        dispatch_valid = 1'b1;
        opcode         = r.op;
        dest           = r.dest;
        src1           = r.src1;
        src2           = r.src2;
        while (!done) begin
            @(negedge clock);
            if (dispatch_stall)
                stall_count++;
            else
                done = 1'b1;
            @(posedge clock);              // Accept edge when not stalled
        end
        record_dispatch(r);
        #10 dispatch_valid = 1'b0;
    endtask

    task automatic check_registers();
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_read_index = reg_index_t'(i);
            @(negedge clock);
            check_data($sformatf("reg_read_value[%0d]", i), reg_read_value, model[i]);
            @(posedge clock);
            #10;
        end
    endtask

    // CDB monitor samples mid-cycle where values are stable
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            cdb_count++;
            if (cdb_tag == TAG_READY) begin
                errors++;
                $display("CDB broadcast carries the ready tag zero");
            end else if (!pending[cdb_tag]) begin
                errors++;
                $display("CDB broadcast of tag 0x%h with no instruction in flight", cdb_tag);
            end else begin
                check_dest("cdb_dest", cdb_dest, exp_dest[cdb_tag]);
                check_data("cdb_value", cdb_value, exp_value[cdb_tag]);
                pending[cdb_tag] = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        #1;
        repeat (prog.size() * 20 + 50) @(posedge clock);
        $display("watchdog expired after %0d clock periods", prog.size() * 20 + 50);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int row;
        seed           = 32'h8d52;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        opcode         = OP_ADD;
        dest           = '0;
        src1           = '0;
        src2           = '0;
        reg_read_index = '0;
        errors         = 0;
        checks         = 0;
        cdb_count      = 0;
        outstanding    = 0;
        next_exp_tag   = tag_t'(1);       // Counter starts above the ready tag
        for (int i = 0; i < NUM_REGS; i++)
            model[i] = data_t'(i);
        for (int t = 0; t < NUM_TAGS; t++)
            pending[t] = 1'b0;
        build_table();
        repeat (3) @(posedge clock);
        #10 reset = 1'b0;
        row = 0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_errors = errors;
            disp_count   = 0;
            stall_count  = 0;
            cdb_count    = 0;
            while (row < prog.size() && prog[row].group == g) begin
                dispatch_row(prog[row]);
                row++;
            end
            while (outstanding != 0)
                @(posedge clock);
            repeat (MULT_STAGES + 1) @(posedge clock);  // Catch stray broadcasts
            #10;
            check_count("cdb broadcasts", cdb_count, disp_count);
            check_registers();
            if (g == STALL_GROUP && stall_count == 0) begin
                errors++;
                $display("third multiply was accepted without dispatch_stall going high");
            end
            $display("test %0d %s: %s", g, test_name[g],
                     (errors == group_errors) ? "ok" : "FAILED");
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_GROUPS, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
